// File: include/edge_macros.svh
`ifndef EDGE_MACROS_SVH
`define EDGE_MACROS_SVH

// Frame geometry, fixed at compile time
`define IMG_WIDTH 16
`define IMG_HEIGHT 12

// Entries in every pipeline FIFO
`define FIFO_DEPTH 16

`endif

// File: design/edge_pkg.sv
package edge_pkg;

    // Red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] rgb_pixel_t;

    // One gray intensity or one Sobel magnitude
    typedef logic [7:0] gray_pixel_t;

    // Sum of three 8-bit channels, up to 765
    typedef logic [9:0] rgb_sum_t;

    // Signed gradient, covers -1020..1020 and the sum of two magnitudes
    typedef logic signed [11:0] grad_t;

    // Horizontal and vertical gradient of one window
    typedef struct packed {
        grad_t gx;
        grad_t gy;
    } gradient_t;

    typedef enum logic [1:0] {
        PROLOGUE,
        FILTER,
        OUTPUT
    } sobel_state_t;

endpackage

// File: design/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo #(
    parameter int data_width = 8,
    parameter int depth = 16
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic [data_width-1:0] din,
    input  logic                  rd_en,
    output logic                  full,
    output logic                  empty,
    output logic [data_width-1:0] dout
);

    localparam int addr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);
    localparam logic [addr_width-1:0] last_addr = addr_width'(depth - 1);
    localparam logic [count_width-1:0] full_count = count_width'(depth);

    logic [data_width-1:0] mem [depth];
    logic [addr_width-1:0] wr_ptr;
    logic [addr_width-1:0] rd_ptr;
    logic [count_width-1:0] count;
    logic wr_fire;
    logic rd_fire;

    assign full = (count == full_count);
    assign empty = (count == '0);

    // First word falls through to the output
    assign dout = mem[rd_ptr];

    assign wr_fire = wr_en && !full;
    assign rd_fire = rd_en && !empty;

    always_ff @(posedge clock) begin
        if (wr_fire) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == last_addr) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == last_addr) ? '0 : rd_ptr + 1'b1;
            end
            // Occupancy only moves when exactly one side fires
            case ({wr_fire, rd_fire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    no_write_when_full: assert property (
        @(posedge clock) disable iff (reset) wr_en |-> !full
    ) else $error("pixel_fifo written while full");

    no_read_when_empty: assert property (
        @(posedge clock) disable iff (reset) rd_en |-> !empty
    ) else $error("pixel_fifo read while empty");

endmodule

// File: design/grayscale.sv
`timescale 1ns/1ps

module grayscale
    import edge_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        in_empty,
    input  rgb_pixel_t  in_dout,
    input  logic        out_full,
    output logic        in_rd_en,
    output logic        out_wr_en,
    output gray_pixel_t out_din
);

    rgb_sum_t    channel_sum;
    gray_pixel_t gray_q;
    logic        valid_q;

    assign channel_sum = rgb_sum_t'(in_dout[23:16]) + rgb_sum_t'(in_dout[15:8])
                       + rgb_sum_t'(in_dout[7:0]);

    // Drain the holding register whenever the next FIFO has room
    assign out_wr_en = valid_q && !out_full;
    assign out_din = gray_q;

    // Refill when the register is free or empties this cycle
    assign in_rd_en = !in_empty && (!valid_q || !out_full);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_rd_en) begin
            valid_q <= 1'b1;
        end else if (out_wr_en) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            // Average of the three channels, quotient fits in 8 bits
            gray_q <= gray_pixel_t'(channel_sum / rgb_sum_t'(3));
        end
    end

    // A stalled pixel stays put until the middle FIFO takes it
    hold_under_stall: assert property (
        @(posedge clock) disable iff (reset)
        valid_q && out_full |=> valid_q && $stable(gray_q)
    ) else $error("grayscale lost a pixel under back-pressure");

endmodule

// File: design/sobel_filter.sv
`timescale 1ns/1ps
`include "edge_macros.svh"

module sobel_filter
    import edge_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        in_empty,
    input  gray_pixel_t in_dout,
    input  logic        out_full,
    output logic        in_rd_en,
    output logic        out_wr_en,
    output gray_pixel_t out_din
);

    localparam int width = `IMG_WIDTH;
    localparam int height = `IMG_HEIGHT;
    localparam int sr_len = 2 * width + 3;
    localparam int col_bits = $clog2(width);
    localparam int row_bits = $clog2(height);
    localparam int cnt_bits = $clog2(width + 3);

    localparam logic [col_bits-1:0] last_col = col_bits'(width - 1);
    localparam logic [row_bits-1:0] last_row = row_bits'(height - 1);
    localparam logic [col_bits-1:0] flush_col = col_bits'(width - 2);
    localparam logic [row_bits-1:0] flush_row = row_bits'(height - 2);
    localparam logic [cnt_bits-1:0] prologue_last = cnt_bits'(width + 1);

    sobel_state_t state;
    sobel_state_t next_state;

    // Two lines plus three pixels, newest at the highest index
    gray_pixel_t [0:sr_len-1] shift_reg;
    logic        shift_en;
    gray_pixel_t shift_in;

    logic [cnt_bits-1:0] counter;
    logic [cnt_bits-1:0] counter_c;
    logic [col_bits-1:0] col;
    logic [col_bits-1:0] col_c;
    logic [row_bits-1:0] row;
    logic [row_bits-1:0] row_c;

    logic flush;
    logic border;
    logic grad_load;

    grad_t p1, p2, p3, p4, p6, p7, p8, p9;
    gradient_t window_grad;
    gradient_t grad;
    grad_t abs_gx;
    grad_t abs_gy;
    grad_t grad_sum;
    grad_t half_sum;

    function automatic grad_t widen(input gray_pixel_t pixel);
        return {4'b0000, pixel};
    endfunction

    // 3x3 neighborhood around shift_reg[width + 1]
    assign p1 = widen(shift_reg[0]);
    assign p2 = widen(shift_reg[1]);
    assign p3 = widen(shift_reg[2]);
    assign p4 = widen(shift_reg[width]);
    assign p6 = widen(shift_reg[width + 2]);
    assign p7 = widen(shift_reg[2 * width]);
    assign p8 = widen(shift_reg[2 * width + 1]);
    assign p9 = widen(shift_reg[2 * width + 2]);

    assign window_grad.gx = (p3 + (p6 <<< 1) + p9) - (p1 + (p4 <<< 1) + p7);
    assign window_grad.gy = (p7 + (p8 <<< 1) + p9) - (p1 + (p2 <<< 1) + p3);

    // row and col name the center pixel of the window
    assign border = (row == '0) || (row == last_row) || (col == '0) || (col == last_col);

    // Last width+2 centers have no real pixel left to pull in
    assign flush = (row == last_row) || ((row == flush_row) && (col >= flush_col));

    assign abs_gx = (grad.gx < 0) ? -grad.gx : grad.gx;
    assign abs_gy = (grad.gy < 0) ? -grad.gy : grad.gy;
    assign grad_sum = abs_gx + abs_gy;
    assign half_sum = grad_sum >>> 1;

    // Saturate at full scale
    assign out_din = (half_sum > grad_t'(255)) ? 8'hFF : half_sum[7:0];

    always_comb begin
        next_state = state;
        counter_c = counter;
        col_c = col;
        row_c = row;
        in_rd_en = 1'b0;
        out_wr_en = 1'b0;
        shift_en = 1'b0;
        shift_in = in_dout;
        grad_load = 1'b0;

        case (state)
            PROLOGUE: begin
                // Fill the window until pixel 0 sits at the center
                if (!in_empty) begin
                    in_rd_en = 1'b1;
                    shift_en = 1'b1;
                    counter_c = counter + 1'b1;
                    if (counter == prologue_last) begin
                        next_state = FILTER;
                    end
                end
            end
            FILTER: begin
                if (flush || !in_empty) begin
                    in_rd_en = !flush;
                    shift_en = 1'b1;
                    shift_in = flush ? '0 : in_dout;
                    grad_load = 1'b1;
                    if (col == last_col) begin
                        col_c = '0;
                        row_c = (row == last_row) ? '0 : row + 1'b1;
                    end else begin
                        col_c = col + 1'b1;
                    end
                    next_state = OUTPUT;
                end
            end
            OUTPUT: begin
                if (!out_full) begin
                    out_wr_en = 1'b1;
                    // Counters wrapped to zero after the last center
                    if (row == '0 && col == '0) begin
                        counter_c = '0;
                        next_state = PROLOGUE;
                    end else begin
                        next_state = FILTER;
                    end
                end
            end
            default: begin
                next_state = PROLOGUE;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= PROLOGUE;
            counter <= '0;
            col <= '0;
            row <= '0;
        end else begin
            state <= next_state;
            counter <= counter_c;
            col <= col_c;
            row <= row_c;
        end
    end

    always_ff @(posedge clock) begin
        if (shift_en) begin
            shift_reg <= {shift_reg[1:sr_len-1], shift_in};
        end
        if (grad_load) begin
            grad <= border ? '0 : window_grad;
        end
    end

    // A stalled result keeps its value until the output FIFO takes it
    hold_under_stall: assert property (
        @(posedge clock) disable iff (reset)
        (state == OUTPUT) && out_full |=> (state == OUTPUT) && $stable(out_din)
    ) else $error("sobel_filter changed a stalled result");

    // Every frame starts from the top left corner
    prologue_at_origin: assert property (
        @(posedge clock) disable iff (reset)
        (state == PROLOGUE) |-> (row == '0) && (col == '0)
    ) else $error("sobel_filter entered PROLOGUE with stale counters");

endmodule

// File: design/edge_detect_top.sv
`timescale 1ns/1ps
`include "edge_macros.svh"

module edge_detect_top
    import edge_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        in_wr_en,
    input  rgb_pixel_t  in_din,
    input  logic        out_rd_en,
    output logic        in_full,
    output logic        out_empty,
    output gray_pixel_t out_dout
);

    // Input FIFO to grayscale
    logic       rgb_empty;
    logic       rgb_rd_en;
    rgb_pixel_t rgb_dout;

    // Grayscale to middle FIFO
    logic        gray_wr_en;
    logic        gray_full;
    gray_pixel_t gray_din;

    // Middle FIFO to Sobel
    logic        mid_empty;
    logic        mid_rd_en;
    gray_pixel_t mid_dout;

    // Sobel to output FIFO
    logic        edge_wr_en;
    logic        edge_full;
    gray_pixel_t edge_din;

    pixel_fifo #(
        .data_width($bits(rgb_pixel_t)),
        .depth(`FIFO_DEPTH)
    ) in_fifo (
        .clock(clock),
        .reset(reset),
        .wr_en(in_wr_en),
        .din(in_din),
        .rd_en(rgb_rd_en),
        .full(in_full),
        .empty(rgb_empty),
        .dout(rgb_dout)
    );

    grayscale grayscale_inst (
        .clock(clock),
        .reset(reset),
        .in_empty(rgb_empty),
        .in_dout(rgb_dout),
        .out_full(gray_full),
        .in_rd_en(rgb_rd_en),
        .out_wr_en(gray_wr_en),
        .out_din(gray_din)
    );

    pixel_fifo #(
        .data_width($bits(gray_pixel_t)),
        .depth(`FIFO_DEPTH)
    ) mid_fifo (
        .clock(clock),
        .reset(reset),
        .wr_en(gray_wr_en),
        .din(gray_din),
        .rd_en(mid_rd_en),
        .full(gray_full),
        .empty(mid_empty),
        .dout(mid_dout)
    );

    sobel_filter sobel_filter_inst (
        .clock(clock),
        .reset(reset),
        .in_empty(mid_empty),
        .in_dout(mid_dout),
        .out_full(edge_full),
        .in_rd_en(mid_rd_en),
        .out_wr_en(edge_wr_en),
        .out_din(edge_din)
    );

    pixel_fifo #(
        .data_width($bits(gray_pixel_t)),
        .depth(`FIFO_DEPTH)
    ) out_fifo (
        .clock(clock),
        .reset(reset),
        .wr_en(edge_wr_en),
        .din(edge_din),
        .rd_en(out_rd_en),
        .full(edge_full),
        .empty(out_empty),
        .dout(out_dout)
    );

endmodule

// File: verif/edge_detect_tb.sv
`timescale 1ns/1ps
`include "edge_macros.svh"

module edge_detect_tb
    import edge_pkg::*;
();

    localparam int img_width = `IMG_WIDTH;
    localparam int img_height = `IMG_HEIGHT;
    localparam int frame_pixels = img_width * img_height;
    // Six frames pass through the DUT over the whole run
    localparam int timeout_limit = 20 * 6 * frame_pixels;

    logic        clock;
    logic        reset;
    logic        in_wr_en;
    rgb_pixel_t  in_din;
    logic        out_rd_en;
    logic        in_full;
    logic        out_empty;
    gray_pixel_t out_dout;

    rgb_pixel_t  frames [2][frame_pixels];
    logic [31:0] rng_state;
    int          cycle_count = 0;
    int          error_count;
    int          pass_count;
    int          fail_count;
    bit          saw_full;

    edge_detect_top edge_detect_top_inst (
        .clock(clock),
        .reset(reset),
        .in_wr_en(in_wr_en),
        .in_din(in_din),
        .out_rd_en(out_rd_en),
        .in_full(in_full),
        .out_empty(out_empty),
        .out_dout(out_dout)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("timeout: run exceeded %0d cycles without finishing", timeout_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Channel average of one stored pixel
    function automatic int gray_at(input int f, input int row, input int col);
        rgb_pixel_t pixel;
        pixel = frames[f][row * img_width + col];
        return (int'(pixel[23:16]) + int'(pixel[15:8]) + int'(pixel[7:0])) / 3;
    endfunction

    // Expected Sobel magnitude for one pixel of a stored frame
    function automatic gray_pixel_t model_edge(input int f, input int row, input int col);
        int gx;
        int gy;
        int mag;
        if (row == 0 || row == img_height - 1 || col == 0 || col == img_width - 1) begin
            return '0;
        end
        gx = (gray_at(f, row - 1, col + 1) + 2 * gray_at(f, row, col + 1)
              + gray_at(f, row + 1, col + 1))
           - (gray_at(f, row - 1, col - 1) + 2 * gray_at(f, row, col - 1)
              + gray_at(f, row + 1, col - 1));
        gy = (gray_at(f, row + 1, col - 1) + 2 * gray_at(f, row + 1, col)
              + gray_at(f, row + 1, col + 1))
           - (gray_at(f, row - 1, col - 1) + 2 * gray_at(f, row - 1, col)
              + gray_at(f, row - 1, col + 1));
        mag = ((gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy)) / 2;
        return gray_pixel_t'(mag > 255 ? 255 : mag);
    endfunction

    task automatic check_gray(input string name, input gray_pixel_t expected,
                              input gray_pixel_t actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic expect_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %b, actual %b", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_error(input string name, input string what);
        $display("error in %s: %s", name, what);
        error_count++;
    endtask

    task automatic fill_random(input int f);
        for (int i = 0; i < frame_pixels; i++) begin
            rng_state = xorshift(rng_state);
            frames[f][i] = rng_state[23:0];
        end
    endtask

    // One write every other cycle, full sampled between edges
    task automatic write_frames(input int nframes);
        for (int f = 0; f < nframes; f++) begin
            for (int i = 0; i < frame_pixels; i++) begin
                @(negedge clock);
                while (in_full) begin
                    saw_full = 1'b1;
                    @(negedge clock);
                end
                @(posedge clock);
                in_wr_en <= 1'b1;
                in_din <= frames[f][i];
                @(posedge clock);
                in_wr_en <= 1'b0;
            end
        end
    endtask

    task automatic read_results(input string name, input int nframes, input bit stall);
        int pix;
        for (int k = 0; k < nframes * frame_pixels; k++) begin
            if (stall) begin
                rng_state = xorshift(rng_state);
                if (rng_state[1:0] != 2'b00) begin
                    repeat (int'(rng_state[6:2])) @(negedge clock);
                end
            end
            @(negedge clock);
            while (out_empty) begin
                @(negedge clock);
            end
            pix = k % frame_pixels;
            check_gray($sformatf("%s pixel %0d", name, k),
                       model_edge(k / frame_pixels, pix / img_width, pix % img_width),
                       out_dout);
            @(posedge clock);
            out_rd_en <= 1'b1;
            @(posedge clock);
            out_rd_en <= 1'b0;
        end
    endtask

    task automatic check_idle(input string name);
        bit extra;
        extra = 1'b0;
        repeat (4 * img_width) begin
            @(negedge clock);
            if (!out_empty) begin
                extra = 1'b1;
            end
        end
        if (extra) begin
            report_error(name, "output FIFO holds results beyond the expected count");
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %s passed", name);
        end else begin
            fail_count++;
            $display("test %s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic run_frames(input string name, input int nframes, input bit stall);
        int errors_before;
        errors_before = error_count;
        saw_full = 1'b0;
        fork
            write_frames(nframes);
            read_results(name, nframes, stall);
        join
        check_idle(name);
        if (stall && !saw_full) begin
            report_error(name, "input FIFO never filled while the reader stalled");
        end
        finish_test(name, errors_before);
    endtask

    task automatic reset_state();
        int errors_before;
        errors_before = error_count;
        @(negedge clock);
        expect_flag("reset_state out_empty", 1'b1, out_empty);
        expect_flag("reset_state in_full", 1'b0, in_full);
        check_idle("reset_state");
        finish_test("reset_state", errors_before);
    endtask

    task automatic flat_frame();
        for (int i = 0; i < frame_pixels; i++) begin
            frames[0][i] = 24'h4080C0;
        end
        run_frames("flat_frame", 1, 1'b0);
    endtask

    task automatic vertical_edge();
        // Black left half, white right half
        for (int i = 0; i < frame_pixels; i++) begin
            frames[0][i] = (i % img_width < img_width / 2) ? 24'h000000 : 24'hFFFFFF;
        end
        run_frames("vertical_edge", 1, 1'b0);
    endtask

    task automatic random_frame();
        fill_random(0);
        run_frames("random_frame", 1, 1'b0);
    endtask

    task automatic back_pressure();
        fill_random(0);
        run_frames("back_pressure", 1, 1'b1);
    endtask

    task automatic back_to_back_frames();
        fill_random(0);
        fill_random(1);
        run_frames("back_to_back", 2, 1'b0);
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        in_wr_en = 1'b0;
        in_din = '0;
        out_rd_en = 1'b0;
        rng_state = 32'd53;
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;

        reset_state();
        flat_frame();
        vertical_edge();
        random_frame();
        back_pressure();
        back_to_back_frames();

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
design/edge_pkg.sv
design/pixel_fifo.sv
design/grayscale.sv
design/sobel_filter.sv
design/edge_detect_top.sv
verif/edge_detect_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the edge detector testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module edge_detect_tb \
    -Mdir obj_dir -o edge_detect_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/edge_detect_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "no result line found in sim.log"
    exit 1
fi
exit 0
